// ==== project.f ====
rtl/spi_pkg.sv
rtl/spi_clock_gen.sv
rtl/spi_tx_fifo.sv
rtl/spi_master_io.sv
rtl/spi_regs.sv
rtl/spi_master.sv
sim/spi_slave_model.sv
sim/spi_master_tb.sv

// ==== rtl/spi_clock_gen.sv ====
`timescale 1ns/1ps

module spi_clock_gen (
   input  logic             clk,
   input  logic             nreset,
   input  logic             clk_en,      // high while a transfer is open
   input  spi_pkg::clkdiv_t clkdiv,      // half-period length minus one
   output logic             sclk_level,  // 1 after a leading strobe
   output logic             edge_lead,   // start of odd half-period
   output logic             edge_trail   // start of even half-period
);

   spi_pkg::clkdiv_t cnt;    // counts down to the next strobe
   logic             phase;  // which strobe comes next
   logic             tick;

   // strobe in the first enabled cycle, then every clkdiv+1 cycles
   assign tick       = clk_en & (cnt == '0);
   assign edge_lead  = tick & ~phase;
   assign edge_trail = tick & phase;
   assign sclk_level = phase;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         cnt   <= '0;
         phase <= 1'b0;
      end else if (!clk_en) begin
         cnt   <= '0;            // parked, ready to fire on enable
         phase <= 1'b0;
      end else if (tick) begin
         cnt   <= clkdiv;        // reload
         phase <= ~phase;        // lead and trail alternate
      end else begin
         cnt   <= cnt - 1'b1;
      end
   end

   // ##############################
   // checks
   // ##############################

   // divider must not move under an open transfer
   a_clkdiv_stable : assert property (
      @(posedge clk) disable iff (!nreset)
      (clk_en && $past(clk_en)) |-> $stable(clkdiv)
   ) else $error("clkdiv changed while clk_en high");

endmodule

// ==== rtl/spi_master.sv ====
`timescale 1ns/1ps

module spi_master (
   input  logic               clk,
   input  logic               nreset,
   // host register bus
   input  logic               reg_write,
   input  logic               reg_read,
   input  spi_pkg::reg_addr_t reg_addr,
   input  spi_pkg::reg_data_t reg_wdata,
   output spi_pkg::reg_data_t reg_rdata,
   output logic               irq,
   // spi pins
   output logic               sclk,
   output logic               mosi,
   output logic               ss,
   input  logic               miso
);

   logic               cpol;
   logic               cpha;
   logic               lsbfirst;
   logic               manual_mode;
   logic               send_data;
   spi_pkg::clkdiv_t   clkdiv;
   logic               push;
   spi_pkg::spi_byte_t push_data;
   logic               pop;
   spi_pkg::spi_byte_t fifo_dout;
   logic               fifo_empty;
   logic               fifo_full;
   logic               busy;
   spi_pkg::rx_shift_t rx_data;
   logic               rx_done;

   spi_regs regs_i (
      .clk         (clk),
      .nreset      (nreset),
      .reg_write   (reg_write),
      .reg_read    (reg_read),
      .reg_addr    (reg_addr),
      .reg_wdata   (reg_wdata),
      .reg_rdata   (reg_rdata),
      .irq         (irq),
      .cpol        (cpol),
      .cpha        (cpha),
      .lsbfirst    (lsbfirst),
      .manual_mode (manual_mode),
      .send_data   (send_data),
      .clkdiv      (clkdiv),
      .push        (push),
      .push_data   (push_data),
      .fifo_empty  (fifo_empty),
      .fifo_full   (fifo_full),
      .busy        (busy),
      .rx_data     (rx_data),
      .rx_done     (rx_done)
   );

   // tx bytes between host and engine
   spi_tx_fifo fifo_i (
      .clk        (clk),
      .nreset     (nreset),
      .push       (push),
      .push_data  (push_data),
      .pop        (pop),
      .fifo_dout  (fifo_dout),
      .fifo_empty (fifo_empty),
      .fifo_full  (fifo_full)
   );

   spi_master_io io_i (
      .clk         (clk),
      .nreset      (nreset),
      .cpol        (cpol),
      .cpha        (cpha),
      .lsbfirst    (lsbfirst),
      .manual_mode (manual_mode),
      .send_data   (send_data),
      .clkdiv      (clkdiv),
      .fifo_dout   (fifo_dout),
      .fifo_empty  (fifo_empty),
      .pop         (pop),
      .busy        (busy),
      .rx_data     (rx_data),
      .rx_done     (rx_done),
      .sclk        (sclk),
      .mosi        (mosi),
      .ss          (ss),
      .miso        (miso)
   );

endmodule

// ==== rtl/spi_master_io.sv ====
`timescale 1ns/1ps

module spi_master_io (
   input  logic               clk,
   input  logic               nreset,
   input  logic               cpol,         // sclk idle level
   input  logic               cpha,         // 1 = sample on trailing edge
   input  logic               lsbfirst,
   input  logic               manual_mode,  // ss from send_data
   input  logic               send_data,
   input  spi_pkg::clkdiv_t   clkdiv,
   input  spi_pkg::spi_byte_t fifo_dout,
   input  logic               fifo_empty,
   output logic               pop,
   output logic               busy,
   output spi_pkg::rx_shift_t rx_data,
   output logic               rx_done,      // pulse after ss rises
   output logic               sclk,
   output logic               mosi,
   output logic               ss,
   input  logic               miso
);

   spi_pkg::spi_state_t state;
   logic                clk_en;
   logic                sclk_level;
   logic                edge_lead;
   logic                edge_trail;
   logic                tick;
   logic                in_data;
   logic                byte_end;
   logic                sample_edge;
   logic                shift_edge;
   logic [3:0]          edge_cnt;    // half-periods inside a byte
   spi_pkg::spi_byte_t  tx_sr;
   spi_pkg::rx_shift_t  rx_sr;
   logic                ss_q;

   spi_clock_gen clock_gen_i (
      .clk        (clk),
      .nreset     (nreset),
      .clk_en     (clk_en),
      .clkdiv     (clkdiv),
      .sclk_level (sclk_level),
      .edge_lead  (edge_lead),
      .edge_trail (edge_trail)
   );

   assign clk_en  = (state != spi_pkg::IDLE);
   assign busy    = clk_en;                      // any phase but idle
   assign tick    = edge_lead | edge_trail;
   assign in_data = (state == spi_pkg::DATA);

   // 8th trailing edge closes the byte
   assign byte_end = in_data & edge_trail & (edge_cnt == 4'd15);

   // fetch on idle, or chain the next byte at byte end
   assign pop = ~fifo_empty & ((state == spi_pkg::IDLE) | byte_end);

   // cpha 0 samples lead, shifts trail; cpha 1 the other way round
   assign sample_edge = in_data & (cpha ? edge_trail : edge_lead);
   assign shift_edge  = in_data & (cpha ? (edge_lead & (edge_cnt != 4'd0)) : edge_trail);

   // ##############################
   // phase sequencer
   // ##############################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         state <= spi_pkg::IDLE;
      end else begin
         case (state)
            spi_pkg::IDLE:   if (!fifo_empty) state <= spi_pkg::SETUP;
            spi_pkg::SETUP:  if (edge_trail) state <= spi_pkg::DATA;
            spi_pkg::DATA:   if (byte_end && fifo_empty) state <= spi_pkg::HOLD;
            spi_pkg::HOLD:   if (edge_lead) state <= spi_pkg::MARGIN;
            spi_pkg::MARGIN: if (edge_trail) state <= spi_pkg::IDLE;
            default:         state <= spi_pkg::IDLE;
         endcase
      end
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         edge_cnt <= '0;
      end else if (!in_data) begin
         edge_cnt <= '0;
      end else if (tick) begin
         edge_cnt <= edge_cnt + 1'b1;   // wraps for back to back bytes
      end
   end

   // ##############################
   // serializer / deserializer
   // ##############################
   always_ff @(posedge clk) begin
      if (pop) begin
         tx_sr <= fifo_dout;                  // valid from the cycle after pop
      end else if (shift_edge) begin
         tx_sr <= lsbfirst ? {1'b0, tx_sr[7:1]} : {tx_sr[6:0], 1'b0};
      end
   end

   assign mosi = lsbfirst ? tx_sr[0] : tx_sr[7];

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         rx_sr <= '0;
      end else if (sample_edge) begin
         rx_sr <= lsbfirst ? {miso, rx_sr[63:1]} : {rx_sr[62:0], miso};
      end
   end

   assign rx_data = rx_sr;

   // sclk toggles only inside data, parked at cpol otherwise
   assign sclk = cpol ^ (sclk_level & in_data);

   // ss low setup..hold unless host drives it
   assign ss = manual_mode ? ~send_data
                           : ~(state inside {spi_pkg::SETUP, spi_pkg::DATA, spi_pkg::HOLD});

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         ss_q    <= 1'b1;
         rx_done <= 1'b0;
      end else begin
         ss_q    <= ss;
         rx_done <= ss & ~ss_q;      // rising ss, one cycle late
      end
   end

endmodule

// ==== rtl/spi_pkg.sv ====
package spi_pkg;

   // ##############################
   // widths with a meaning
   // ##############################
   typedef logic [3:0]  reg_addr_t;   // host register index
   typedef logic [31:0] reg_data_t;   // host bus word
   typedef logic [7:0]  spi_byte_t;   // one byte on the wire
   typedef logic [63:0] rx_shift_t;   // last eight bytes received
   typedef logic [7:0]  clkdiv_t;     // half-period = clkdiv+1 cycles

   // transfer phases of the engine
   typedef enum logic [2:0] {
      IDLE   = 3'd0,  // ss high, sclk parked
      SETUP  = 3'd1,  // ss low, first bit on mosi
      DATA   = 3'd2,  // 16 half-periods per byte
      HOLD   = 3'd3,  // ss still low after last edge
      MARGIN = 3'd4   // gap before next window
   } spi_state_t;

   // ##############################
   // register map
   // ##############################
   localparam reg_addr_t ADDR_CONFIG = 4'd0;
   localparam reg_addr_t ADDR_CLKDIV = 4'd1;
   localparam reg_addr_t ADDR_TXDATA = 4'd2;  // write only
   localparam reg_addr_t ADDR_STATUS = 4'd3;  // read clears rx_ready, overflow
   localparam reg_addr_t ADDR_RXLOW  = 4'd4;
   localparam reg_addr_t ADDR_RXHIGH = 4'd5;

   // config bits
   localparam int CFG_CPOL     = 0;
   localparam int CFG_CPHA     = 1;
   localparam int CFG_LSBFIRST = 2;
   localparam int CFG_MANUAL   = 3;
   localparam int CFG_SEND     = 4;

   // status bits
   localparam int ST_BUSY     = 0;
   localparam int ST_EMPTY    = 1;
   localparam int ST_FULL     = 2;
   localparam int ST_RX_READY = 3;
   localparam int ST_OVERFLOW = 4;

   localparam int FIFO_DEPTH = 4;  // tx bytes buffered

endpackage

// ==== rtl/spi_regs.sv ====
`timescale 1ns/1ps

module spi_regs (
   input  logic               clk,
   input  logic               nreset,
   input  logic               reg_write,
   input  logic               reg_read,
   input  spi_pkg::reg_addr_t reg_addr,
   input  spi_pkg::reg_data_t reg_wdata,
   output spi_pkg::reg_data_t reg_rdata,   // valid cycle after reg_read
   output logic               irq,
   output logic               cpol,
   output logic               cpha,
   output logic               lsbfirst,
   output logic               manual_mode,
   output logic               send_data,
   output spi_pkg::clkdiv_t   clkdiv,
   output logic               push,
   output spi_pkg::spi_byte_t push_data,
   input  logic               fifo_empty,
   input  logic               fifo_full,
   input  logic               busy,
   input  spi_pkg::rx_shift_t rx_data,
   input  logic               rx_done
);

   logic               wr_txdata;
   logic               rd_status;
   logic               rx_ready;    // new rx capture not yet seen
   logic               overflow;    // sticky, tx write dropped
   spi_pkg::rx_shift_t rx_cap;
   spi_pkg::reg_data_t rd_mux;

   assign wr_txdata = reg_write & (reg_addr == spi_pkg::ADDR_TXDATA);
   assign rd_status = reg_read & (reg_addr == spi_pkg::ADDR_STATUS);
   assign push      = wr_txdata & ~fifo_full;   // full fifo drops the byte
   assign push_data = reg_wdata[7:0];

   // ##############################
   // config
   // ##############################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         cpol        <= 1'b0;
         cpha        <= 1'b0;
         lsbfirst    <= 1'b0;
         manual_mode <= 1'b0;
         send_data   <= 1'b0;
         clkdiv      <= '0;
      end else if (reg_write) begin
         if (reg_addr == spi_pkg::ADDR_CONFIG) begin
            cpol        <= reg_wdata[spi_pkg::CFG_CPOL];
            cpha        <= reg_wdata[spi_pkg::CFG_CPHA];
            lsbfirst    <= reg_wdata[spi_pkg::CFG_LSBFIRST];
            manual_mode <= reg_wdata[spi_pkg::CFG_MANUAL];
            send_data   <= reg_wdata[spi_pkg::CFG_SEND];
         end
         if (reg_addr == spi_pkg::ADDR_CLKDIV) begin
            clkdiv <= reg_wdata[7:0];
         end
      end
   end

   // status flags, set wins over read-clear
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         overflow <= 1'b0;
         rx_ready <= 1'b0;
         irq      <= 1'b0;
      end else begin
         if (wr_txdata && fifo_full) overflow <= 1'b1;
         else if (rd_status)         overflow <= 1'b0;
         if (rx_done)                rx_ready <= 1'b1;
         else if (rd_status)         rx_ready <= 1'b0;
         irq <= rx_done;                             // lines up with capture
      end
   end

   always_ff @(posedge clk) begin
      if (rx_done) begin
         rx_cap <= rx_data;   // snapshot at ss rise
      end
   end

   // ##############################
   // readback
   // ##############################
   always_comb begin
      rd_mux = '0;
      case (reg_addr)
         spi_pkg::ADDR_CONFIG: begin
            rd_mux[spi_pkg::CFG_CPOL]     = cpol;
            rd_mux[spi_pkg::CFG_CPHA]     = cpha;
            rd_mux[spi_pkg::CFG_LSBFIRST] = lsbfirst;
            rd_mux[spi_pkg::CFG_MANUAL]   = manual_mode;
            rd_mux[spi_pkg::CFG_SEND]     = send_data;
         end
         spi_pkg::ADDR_CLKDIV: rd_mux[7:0] = clkdiv;
         spi_pkg::ADDR_STATUS: begin
            rd_mux[spi_pkg::ST_BUSY]     = busy;
            rd_mux[spi_pkg::ST_EMPTY]    = fifo_empty;
            rd_mux[spi_pkg::ST_FULL]     = fifo_full;
            rd_mux[spi_pkg::ST_RX_READY] = rx_ready;
            rd_mux[spi_pkg::ST_OVERFLOW] = overflow;
         end
         spi_pkg::ADDR_RXLOW:  rd_mux = rx_cap[31:0];
         spi_pkg::ADDR_RXHIGH: rd_mux = rx_cap[63:32];
         default:              rd_mux = '0;   // txdata reads as zero
      endcase
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         reg_rdata <= '0;
      end else if (reg_read) begin
         reg_rdata <= rd_mux;
      end
   end

endmodule

// ==== rtl/spi_tx_fifo.sv ====
`timescale 1ns/1ps

module spi_tx_fifo (
   input  logic               clk,
   input  logic               nreset,
   input  logic               push,        // write strobe from regs
   input  spi_pkg::spi_byte_t push_data,
   input  logic               pop,         // read strobe from engine
   output spi_pkg::spi_byte_t fifo_dout,   // head of queue, no latency
   output logic               fifo_empty,
   output logic               fifo_full
);

   localparam int PTR_W = $clog2(spi_pkg::FIFO_DEPTH);
   localparam int CNT_W = $clog2(spi_pkg::FIFO_DEPTH + 1);

   spi_pkg::spi_byte_t mem [spi_pkg::FIFO_DEPTH];  // storage, no reset
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic [CNT_W-1:0]   count;

   assign fifo_dout  = mem[rd_ptr];
   assign fifo_empty = (count == '0);
   assign fifo_full  = (count == CNT_W'(spi_pkg::FIFO_DEPTH));

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // pointers wrap at depth
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(spi_pkg::FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(spi_pkg::FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;        // both or neither
         endcase
      end
   end

   // ##############################
   // neighbours must respect flags
   // ##############################
   a_no_push_full : assert property (
      @(posedge clk) disable iff (!nreset) push |-> !fifo_full
   ) else $error("push into full tx fifo");

   a_no_pop_empty : assert property (
      @(posedge clk) disable iff (!nreset) pop |-> !fifo_empty
   ) else $error("pop from empty tx fifo");

endmodule

// ==== sim/spi_master_tb.sv ====
`timescale 1ns/1ps

module spi_master_tb;

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 8;
   // 8 transfers x 10 bytes x 20 half-periods x 256 cycles plus margin
   localparam longint WATCHDOG_CYCLES = 64'd8 * 10 * 20 * 256 + 64'd10000;

   logic               clk;
   logic               nreset;
   logic               reg_write;
   logic               reg_read;
   spi_pkg::reg_addr_t reg_addr;
   spi_pkg::reg_data_t reg_wdata;
   spi_pkg::reg_data_t reg_rdata;
   logic               irq;
   logic               sclk;
   logic               mosi;
   logic               ss;
   logic               miso;

   // mode the slave is told about
   logic               cfg_cpol;
   logic               cfg_cpha;
   logic               cfg_lsbfirst;

   int                 seed = 57791;
   int                 err_cnt = 0;
   int                 test_err_start = 0;
   int                 pass_cnt = 0;
   int                 fail_cnt = 0;
   int                 ss_rises = 0;
   spi_pkg::spi_byte_t tx_bytes [0:7];        // bytes of the next transfer
   spi_pkg::spi_byte_t echo_byte = 8'hA5;     // slave's next answer
   spi_pkg::rx_shift_t exp_rx = '0;           // expected receive history

   spi_master spi_master_i (
      .clk       (clk),
      .nreset    (nreset),
      .reg_write (reg_write),
      .reg_read  (reg_read),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .reg_rdata (reg_rdata),
      .irq       (irq),
      .sclk      (sclk),
      .mosi      (mosi),
      .ss        (ss),
      .miso      (miso)
   );

   spi_slave_model slave_i (
      .clk      (clk),
      .cpol     (cfg_cpol),
      .cpha     (cfg_cpha),
      .lsbfirst (cfg_lsbfirst),
      .sclk     (sclk),
      .mosi     (mosi),
      .ss       (ss),
      .miso     (miso)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge ss) begin
      if (nreset === 1'b1) ss_rises++;   // one per closed window
   end

   // ##############################
   // checks and bus tasks
   // ##############################
   task automatic check_val(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
      assert (got === exp) else begin
         $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic require(input logic cond, input string what);
      assert (cond === 1'b1) else begin
         $display("ERROR: %s", what);
         err_cnt++;
      end
   endtask

   // all bus tasks start and end on a falling edge
   task automatic reg_wr(input spi_pkg::reg_addr_t addr, input spi_pkg::reg_data_t data);
      reg_write = 1'b1;
      reg_addr  = addr;
      reg_wdata = data;
      @(negedge clk);
      reg_write = 1'b0;
   endtask

   task automatic reg_rd(input spi_pkg::reg_addr_t addr, output spi_pkg::reg_data_t data);
      reg_read = 1'b1;
      reg_addr = addr;
      @(negedge clk);
      reg_read = 1'b0;
      data     = reg_rdata;   // registered so valid one cycle on
   endtask

   function automatic spi_pkg::spi_byte_t rand_byte();
      logic [31:0] r;
      r = $random(seed);
      return r[7:0];
   endfunction

   task automatic set_mode(input logic cp, input logic ph, input logic lsb,
                           input logic man, input logic snd);
      spi_pkg::reg_data_t d;
      d = '0;
      d[spi_pkg::CFG_CPOL]     = cp;
      d[spi_pkg::CFG_CPHA]     = ph;
      d[spi_pkg::CFG_LSBFIRST] = lsb;
      d[spi_pkg::CFG_MANUAL]   = man;
      d[spi_pkg::CFG_SEND]     = snd;
      cfg_cpol     = cp;
      cfg_cpha     = ph;
      cfg_lsbfirst = lsb;
      reg_wr(spi_pkg::ADDR_CONFIG, d);
   endtask

   // slave answers each byte with the one it got a slot earlier
   task automatic expect_echo(input spi_pkg::spi_byte_t sent);
      if (cfg_lsbfirst) exp_rx = {echo_byte, exp_rx[63:8]};   // enters at the top
      else exp_rx = {exp_rx[55:0], echo_byte};                // enters at the bottom
      echo_byte = sent;
   endtask

   task automatic wait_irq(input int limit);
      int   n;
      logic seen;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < limit) begin
         @(negedge clk);
         n++;
         if (irq === 1'b1) seen = 1'b1;
      end
      require(seen, "irq did not pulse before the timeout");
   endtask

   task automatic wait_idle(input int limit);
      spi_pkg::reg_data_t st;
      int                 n;
      logic               idle;
      n    = 0;
      idle = 1'b0;
      while (!idle && n < limit) begin
         reg_rd(spi_pkg::ADDR_STATUS, st);
         idle = !st[spi_pkg::ST_BUSY] && st[spi_pkg::ST_EMPTY];
         n++;
      end
      require(idle, "engine still busy after the timeout");
   endtask

   task automatic compare_rx();
      spi_pkg::reg_data_t rd;
      reg_rd(spi_pkg::ADDR_RXLOW, rd);
      check_val("RXLOW", rd, exp_rx[31:0]);
      reg_rd(spi_pkg::ADDR_RXHIGH, rd);
      check_val("RXHIGH", rd, exp_rx[63:32]);
   endtask

   // sclk edges of one ss window and the gap before each of them
   task automatic measure_sclk(input int half_cycles, output int edges);
      logic prev;
      int   gap;
      edges = 0;
      gap   = 0;
      while (ss !== 1'b0) @(negedge clk);
      prev = sclk;
      while (ss === 1'b0) begin
         @(negedge clk);
         gap++;
         if (sclk !== prev) begin
            if (edges > 0) check_val("sclk_half_period", gap, half_cycles);
            edges++;
            gap  = 0;
            prev = sclk;
         end
      end
   endtask

   // writes n bytes back to back and checks the whole window
   task automatic run_transfer(input int n, input int div);
      int edges;
      int rises0;
      int i;
      rises0 = ss_rises;
      fork
         measure_sclk(div + 1, edges);
         begin
            for (i = 0; i < n; i++) reg_wr(spi_pkg::ADDR_TXDATA, tx_bytes[i]);
            wait_irq(n * 20 * (div + 1) + 100);
         end
      join
      check_val("sclk_edges", edges, 16 * n);
      check_val("ss_windows", ss_rises - rises0, 1);   // one window for all bytes
      for (i = 0; i < n; i++) expect_echo(tx_bytes[i]);
      compare_rx();
   endtask

   task automatic report_test(input string name);
      if (err_cnt == test_err_start) begin
         $display("test %s: ok", name);
         pass_cnt++;
      end else begin
         $display("test %s: %0d check(s) failed", name, err_cnt - test_err_start);
         fail_cnt++;
      end
      test_err_start = err_cnt;
   endtask

   // ##############################
   // directed tests
   // ##############################
   task automatic reset_values();
      spi_pkg::reg_data_t rd;
      spi_pkg::reg_data_t exp_st;
      exp_st = '0;
      exp_st[spi_pkg::ST_EMPTY] = 1'b1;   // only fifo_empty after reset
      reg_rd(spi_pkg::ADDR_STATUS, rd);
      check_val("STATUS", rd, exp_st);
      check_val("ss", ss, 1'b1);
      check_val("sclk", sclk, 1'b0);
      check_val("irq", irq, 1'b0);
      report_test("reset_values");
   endtask

   task automatic single_byte_mode0();
      spi_pkg::reg_data_t rd;
      set_mode(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      reg_wr(spi_pkg::ADDR_CLKDIV, 32'd3);
      tx_bytes[0] = rand_byte();
      run_transfer(1, 3);
      reg_rd(spi_pkg::ADDR_RXLOW, rd);
      check_val("RXLOW[7:0]", rd[7:0], 8'hA5);   // slave's preload
      reg_rd(spi_pkg::ADDR_STATUS, rd);
      check_val("STATUS.rx_ready", rd[spi_pkg::ST_RX_READY], 1'b1);
      report_test("single_byte_mode0");
   endtask

   task automatic burst_four_bytes();
      int i;
      for (i = 0; i < 4; i++) tx_bytes[i] = rand_byte();
      run_transfer(4, 3);
      report_test("burst_four_bytes");
   endtask

   // modes 1 2 3 msb first then modes 0 and 1 lsb first
   task automatic mode_sweep();
      int         k;
      logic [1:0] md;
      logic       lsb;
      for (k = 1; k <= 5; k++) begin
         md  = k[1:0];
         lsb = (k > 3);
         set_mode(md[1], md[0], lsb, 1'b0, 1'b0);
         check_val("sclk_idle", sclk, md[1]);
         tx_bytes[0] = rand_byte();
         tx_bytes[1] = rand_byte();
         run_transfer(2, 3);
         check_val("sclk_idle", sclk, md[1]);
      end
      report_test("mode_sweep");
   endtask

   task automatic manual_ss();
      int rises0;
      set_mode(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
      check_val("ss", ss, 1'b1);
      set_mode(1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
      check_val("ss", ss, 1'b0);
      rises0 = ss_rises;
      tx_bytes[0] = rand_byte();
      reg_wr(spi_pkg::ADDR_TXDATA, tx_bytes[0]);
      wait_idle(200);
      check_val("ss", ss, 1'b0);                        // engine done but host still holds it
      check_val("ss_rises", ss_rises - rises0, 0);
      set_mode(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
      check_val("ss", ss, 1'b1);
      wait_irq(20);                                     // ss rise closes the window
      expect_echo(tx_bytes[0]);
      compare_rx();
      set_mode(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      report_test("manual_ss");
   endtask

   task automatic overflow_drop();
      spi_pkg::reg_data_t rd;
      int                 i;
      reg_wr(spi_pkg::ADDR_CLKDIV, 32'd15);            // slow byte so the fifo fills up
      for (i = 0; i < 6; i++) tx_bytes[i] = rand_byte();
      reg_wr(spi_pkg::ADDR_TXDATA, tx_bytes[0]);
      repeat (4) @(negedge clk);                        // first byte on the wire
      for (i = 1; i < 6; i++) reg_wr(spi_pkg::ADDR_TXDATA, tx_bytes[i]);
      reg_rd(spi_pkg::ADDR_STATUS, rd);
      check_val("STATUS.overflow", rd[spi_pkg::ST_OVERFLOW], 1'b1);
      check_val("STATUS.fifo_full", rd[spi_pkg::ST_FULL], 1'b1);
      reg_rd(spi_pkg::ADDR_STATUS, rd);
      check_val("STATUS.overflow", rd[spi_pkg::ST_OVERFLOW], 1'b0);
      wait_irq(5 * 20 * 16 + 200);
      for (i = 0; i < 5; i++) expect_echo(tx_bytes[i]);   // sixth one dropped
      compare_rx();
      wait_idle(100);                                   // margin phase still runs on clkdiv
      reg_wr(spi_pkg::ADDR_CLKDIV, 32'd3);
      report_test("overflow_drop");
   endtask

   // ##############################
   // main sequence and watchdog
   // ##############################
   initial begin
      nreset       = 1'b0;
      reg_write    = 1'b0;
      reg_read     = 1'b0;
      reg_addr     = '0;
      reg_wdata    = '0;
      cfg_cpol     = 1'b0;
      cfg_cpha     = 1'b0;
      cfg_lsbfirst = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;
      @(negedge clk);
      reset_values();
      single_byte_mode0();
      burst_four_bytes();
      mode_sweep();
      manual_ss();
      overflow_drop();
      $display("tests passed %0d, failed %0d, failed checks %0d",
               pass_cnt, fail_cnt, err_cnt);
      if (fail_cnt == 0 && err_cnt == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("simulation ran past the watchdog limit and was stopped");
      $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== sim/spi_slave_model.sv ====
`timescale 1ns/1ps

module spi_slave_model (
   input  logic clk,        // bench clock, pins looked at on its falling edge
   input  logic cpol,
   input  logic cpha,
   input  logic lsbfirst,
   input  logic sclk,
   input  logic mosi,
   input  logic ss,
   output logic miso
);

   logic [7:0] reply;       // byte sent back in the next slot
   logic [7:0] rx_byte;
   logic [7:0] tx_byte;
   int         nbits;       // bits taken in the current slot
   logic       sclk_prev;
   logic       mosi_prev;   // mosi as it was before the sclk edge
   logic       ss_prev;
   logic       lead;

   initial begin
      reply     = 8'hA5;    // power-up echo
      rx_byte   = '0;
      tx_byte   = 8'hA5;
      nbits     = 0;
      miso      = 1'b0;
      sclk_prev = 1'b0;
      mosi_prev = 1'b0;
      ss_prev   = 1'b1;
   end

   // pins change just after the rising clk edge, judged half a cycle later
   always @(negedge clk) begin
      if (ss_prev === 1'b1 && ss === 1'b0) begin
         nbits   = 0;                            // window opens
         tx_byte = reply;
         miso    = lsbfirst ? tx_byte[0] : tx_byte[7];
      end else if (ss === 1'b0 && sclk !== sclk_prev) begin
         lead = (sclk !== cpol);
         if (lead != cpha) begin                 // sample edge
            rx_byte = lsbfirst ? {mosi_prev, rx_byte[7:1]} : {rx_byte[6:0], mosi_prev};
            nbits++;
            if (nbits == 8) begin
               reply = rx_byte;                  // echoed in the next slot
               nbits = 0;
            end
         end else begin                          // shift edge
            if (nbits == 0) begin
               tx_byte = reply;                  // new slot
            end else begin
               tx_byte = lsbfirst ? (tx_byte >> 1) : (tx_byte << 1);
            end
            miso = lsbfirst ? tx_byte[0] : tx_byte[7];
         end
      end
      sclk_prev = sclk;
      mosi_prev = mosi;
      ss_prev   = ss;
   end

endmodule
